/* Makefile */
# Verilator build and run for the control plane testbench

VERILATOR ?= verilator
TOP       ?= tb_ctrl_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Result: failure reported, see $(LOG)"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "Result: run ended without a verdict"; exit 1; fi
	@echo "Result: simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/ctrl_bus_if.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

// Command strobes from the SPI slave to the register blocks
interface ctrl_bus_if;

  logic [`CTRL_IOC_W-1:0]  ioc;    // Register index of the current frame
  logic [`CTRL_DATA_W-1:0] wdata;  // Second byte of a write frame
  logic [`CTRL_SEL_N-1:0]  cs;     // One-hot module select that is zero between frames
  logic                    fetch;  // Read strobe, one cycle
  logic                    load;   // Write strobe, one cycle

  // SPI side drives everything
  modport master (
    output ioc,
    output wdata,
    output cs,
    output fetch,
    output load
  );

  // Register blocks only listen
  modport slave (
    input ioc,
    input wdata,
    input cs,
    input fetch,
    input load
  );

endinterface

/* hw/ctrl_bus_pkg.sv */
`include "ctrl_consts.svh"

package ctrl_bus_pkg;

  // Module select field of the command byte
  typedef enum logic [1:0] {
    SEL_SYS  = 2'd0,  // System control block
    SEL_IO   = 2'd1,  // IO control block
    SEL_SMI  = 2'd2,  // Removed block that reads as zero
    SEL_RSVD = 2'd3   // Reserved code
  } ctrl_sel_e;

  // Command byte as it arrives on MOSI, MSB first
  typedef struct packed {
    logic                   rd;   // 1 means read
    ctrl_sel_e              sel;
    logic [`CTRL_IOC_W-1:0] ioc;
  } ctrl_cmd_t;

  // Register map of sys_ctrl
  typedef enum logic [`CTRL_IOC_W-1:0] {
    VERSION = 5'd0,
    SCRATCH = 5'd1
  } sys_ioc_e;

  // Register map of io_ctrl
  typedef enum logic [`CTRL_IOC_W-1:0] {
    RF_MODE = 5'd0,
    PINS    = 5'd1,  // Button over config pins
    LEDS    = 5'd2
  } io_ioc_e;

endpackage

/* hw/ctrl_consts.svh */
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// ==================================================
// Bus widths
// ==================================================
`define CTRL_DATA_W 8       // SPI byte and register data
`define CTRL_IOC_W 5        // Register index inside a block
`define CTRL_SEL_N 4        // Module selects decoded from the command

// ==================================================
// Pin synchronizers
// ==================================================
`define CTRL_SYNC_STAGES 2  // Flops between a pin and the logic

// ==================================================
// Fixed readback values
// ==================================================
`define CTRL_VERSION 8'h01      // System version register
`define CTRL_RESERVED_RD 8'hA5  // Module 3 has no block behind it

`endif

/* hw/ctrl_top.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module ctrl_top (
  input  logic       i_glob_clock,
  input  logic       i_rst_b,

  // SPI from the host
  input  logic       i_sck,
  input  logic       i_ss,
  input  logic       i_mosi,
  output logic       o_miso,

  // Board IO
  input  logic [3:0] i_config,
  input  logic       i_button,
  output logic       o_led0,
  output logic       o_led1,

  // RF front-end switches
  output logic       o_rx_h_tx_l,
  output logic       o_rx_h_tx_l_b,
  output logic       o_tr_vc1,
  output logic       o_tr_vc1_b,
  output logic       o_tr_vc2,
  output logic       o_shdn_rx_lna,
  output logic       o_shdn_tx_lna
);

  // ==================================================
  // Internal signals
  // ==================================================
  logic [`CTRL_DATA_W-1:0] sys_rdata;
  logic [`CTRL_DATA_W-1:0] io_rdata;
  logic [`CTRL_DATA_W-1:0] rd_data_q;   // Byte handed back to the SPI slave
  logic [1:0]              leds;
  rf_fe_pkg::rf_switch_t   rf_sw;

  ctrl_bus_if bus_if ();

  spi_slave spi_slave_inst (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_sck        (i_sck),
    .i_ss         (i_ss),
    .i_mosi       (i_mosi),
    .o_miso       (o_miso),
    .i_read_data  (rd_data_q),
    .bus          (bus_if)
  );

  sys_ctrl sys_ctrl_inst (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .bus          (bus_if),
    .o_rdata      (sys_rdata)
  );

  io_ctrl io_ctrl_inst (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .bus          (bus_if),
    .o_rdata      (io_rdata),
    .i_config     (i_config),
    .i_button     (i_button),
    .o_rf_sw      (rf_sw),
    .o_leds       (leds)
  );

  // Readback mux by module select
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      rd_data_q <= '0;
    end else begin
      case (1'b1)
        bus_if.cs[ctrl_bus_pkg::SEL_SYS]:  rd_data_q <= sys_rdata;
        bus_if.cs[ctrl_bus_pkg::SEL_IO]:   rd_data_q <= io_rdata;
        bus_if.cs[ctrl_bus_pkg::SEL_SMI]:  rd_data_q <= '0;  // SMI block not present
        bus_if.cs[ctrl_bus_pkg::SEL_RSVD]: rd_data_q <= `CTRL_RESERVED_RD;
        default:                           rd_data_q <= '0;  // No frame open
      endcase
    end
  end

  // Pin outputs with complements taken off the same flops
  assign o_rx_h_tx_l   = rf_sw.rx_h_tx_l;
  assign o_rx_h_tx_l_b = ~rf_sw.rx_h_tx_l;
  assign o_tr_vc1      = rf_sw.tr_vc1;
  assign o_tr_vc1_b    = ~rf_sw.tr_vc1;
  assign o_tr_vc2      = rf_sw.tr_vc2;
  assign o_shdn_rx_lna = rf_sw.shdn_rx_lna;
  assign o_shdn_tx_lna = rf_sw.shdn_tx_lna;
  assign o_led0        = leds[0];
  assign o_led1        = leds[1];

endmodule

/* hw/io_ctrl.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module io_ctrl (
  input  logic                    i_glob_clock,
  input  logic                    i_rst_b,
  ctrl_bus_if.slave               bus,
  output logic [`CTRL_DATA_W-1:0] o_rdata,
  input  logic [3:0]              i_config,
  input  logic                    i_button,
  output rf_fe_pkg::rf_switch_t   o_rf_sw,
  output logic [1:0]              o_leds
);

  localparam int sync_n = `CTRL_SYNC_STAGES;
  localparam int mode_w = $bits(rf_fe_pkg::rf_mode_e);
  localparam int pins_w = 5;                      // Button plus four config pins

  logic                          sel;
  logic                          wr_mode;         // Write hits RF_MODE
  rf_fe_pkg::rf_mode_e           rf_mode;         // Code as written with invalid ones kept
  rf_fe_pkg::rf_mode_e           rf_mode_d;
  logic [sync_n-1:0][pins_w-1:0] pin_sync;        // {button, config} pipeline

  assign sel     = bus.cs[ctrl_bus_pkg::SEL_IO];
  assign wr_mode = bus.load && sel && (bus.ioc == ctrl_bus_pkg::RF_MODE);

  // Next mode lets the switches follow in the same cycle as the register
  assign rf_mode_d = wr_mode ? rf_fe_pkg::rf_mode_e'(bus.wdata[mode_w-1:0]) : rf_mode;

  // ==================================================
  // RF switch table
  // ==================================================
  function automatic rf_fe_pkg::rf_switch_t rf_decode(input rf_fe_pkg::rf_mode_e mode);
    rf_fe_pkg::rf_switch_t sw;
    case (mode)
      rf_fe_pkg::RX_LOWPASS: sw = 5'b11101;
      rf_fe_pkg::RX_HIPASS:  sw = 5'b10101;
      rf_fe_pkg::TX_LOWPASS: sw = 5'b01110;
      rf_fe_pkg::TX_HIPASS:  sw = 5'b00110;
      rf_fe_pkg::BYPASS:     sw = 5'b11011;
      default:               sw = 5'b10011;  // LOW_POWER and codes 6, 7
    endcase
    return sw;
  endfunction

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      rf_mode  <= rf_fe_pkg::LOW_POWER;
      o_rf_sw  <= rf_decode(rf_fe_pkg::LOW_POWER);
      o_leds   <= '0;
      pin_sync <= '0;
    end else begin
      rf_mode  <= rf_mode_d;
      o_rf_sw  <= rf_decode(rf_mode_d);   // Registered so the pins never glitch
      pin_sync <= {pin_sync[sync_n-2:0], {i_button, i_config}};
      if (bus.load && sel && bus.ioc == ctrl_bus_pkg::LEDS) begin
        o_leds <= bus.wdata[1:0];
      end
    end
  end

  // ==================================================
  // Readback
  // ==================================================
  always_ff @(posedge i_glob_clock) begin
    if (bus.fetch && sel) begin
      case (bus.ioc)
        ctrl_bus_pkg::RF_MODE: o_rdata <= {{(`CTRL_DATA_W - mode_w){1'b0}}, rf_mode};
        ctrl_bus_pkg::PINS:    o_rdata <= {{(`CTRL_DATA_W - pins_w){1'b0}}, pin_sync[sync_n-1]};
        ctrl_bus_pkg::LEDS:    o_rdata <= {{(`CTRL_DATA_W - 2){1'b0}}, o_leds};
        default:               o_rdata <= '0;
      endcase
    end
  end

endmodule

/* hw/rf_fe_pkg.sv */
package rf_fe_pkg;

  // RF front-end operating modes
  // Codes 6 and 7 are not defined and fall back to LOW_POWER switching
  typedef enum logic [2:0] {
    LOW_POWER  = 3'd0,
    RX_LOWPASS = 3'd1,
    RX_HIPASS  = 3'd2,
    TX_LOWPASS = 3'd3,
    TX_HIPASS  = 3'd4,
    BYPASS     = 3'd5
  } rf_mode_e;

  // Switch levels before the complement outputs are added
  // Field order matches the switch table with rx_h_tx_l in the MSB
  typedef struct packed {
    logic rx_h_tx_l;    // High selects the RX path
    logic tr_vc1;       // T/R switch control 1
    logic tr_vc2;       // T/R switch control 2
    logic shdn_rx_lna;  // RX LNA shutdown
    logic shdn_tx_lna;  // TX LNA shutdown
  } rf_switch_t;

endpackage

/* hw/spi_slave.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module spi_slave (
  input  logic                    i_glob_clock,
  input  logic                    i_rst_b,
  input  logic                    i_sck,
  input  logic                    i_ss,
  input  logic                    i_mosi,
  output logic                    o_miso,
  input  logic [`CTRL_DATA_W-1:0] i_read_data,  // Registered readback from the top mux
  ctrl_bus_if.master              bus
);

  localparam int sync_n     = `CTRL_SYNC_STAGES;
  localparam int data_w     = `CTRL_DATA_W;
  localparam int frame_bits = 2 * data_w;               // Command byte plus data byte
  localparam int cnt_w      = $clog2(frame_bits + 1);

  localparam logic [cnt_w-1:0] cnt_cmd_last   = cnt_w'(data_w - 1);
  localparam logic [cnt_w-1:0] cnt_cmd_done   = cnt_w'(data_w);
  localparam logic [cnt_w-1:0] cnt_frame_last = cnt_w'(frame_bits - 1);
  localparam logic [cnt_w-1:0] cnt_frame_done = cnt_w'(frame_bits);

  // ==================================================
  // Pin synchronizers and edge detect
  // ==================================================
  logic [sync_n-1:0] sck_sync;
  logic [sync_n-1:0] ss_sync;
  logic [sync_n-1:0] mosi_sync;
  logic              sck_prev;    // Last synchronized SCK level

  logic sck_s;
  logic ss_s;
  logic mosi_s;
  logic sck_rise;
  logic sck_fall;

  assign sck_s    = sck_sync[sync_n-1];
  assign ss_s     = ss_sync[sync_n-1];
  assign mosi_s   = mosi_sync[sync_n-1];
  assign sck_rise = sck_s & ~sck_prev;   // Master samples here and we shift in
  assign sck_fall = ~sck_s & sck_prev;   // We change MISO here

  // ==================================================
  // Frame state
  // ==================================================
  logic [cnt_w-1:0]        bit_cnt;      // Rising edges seen in this frame
  logic [data_w-1:0]       rx_shift;     // MOSI bits, newest in the LSB
  logic [data_w-1:0]       rx_byte_next; // Byte completed by the current edge
  logic [data_w-1:0]       tx_shift;     // MISO bits, MSB goes out first
  logic [data_w-1:0]       wdata_q;
  ctrl_bus_pkg::ctrl_cmd_t cmd_q;        // Command of the frame in progress
  ctrl_bus_pkg::ctrl_cmd_t cmd_next;
  logic [`CTRL_SEL_N-1:0]  cs_q;
  logic                    fetch_q;
  logic                    load_q;

  assign rx_byte_next = {rx_shift[data_w-2:0], mosi_s};
  assign cmd_next     = ctrl_bus_pkg::ctrl_cmd_t'(rx_byte_next);

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      sck_sync  <= '0;
      ss_sync   <= '1;             // Idle means deselected
      mosi_sync <= '0;
      sck_prev  <= 1'b0;
      bit_cnt   <= '0;
      tx_shift  <= '0;
      cmd_q     <= '0;
      cs_q      <= '0;
      fetch_q   <= 1'b0;
      load_q    <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[sync_n-2:0], i_sck};
      ss_sync   <= {ss_sync[sync_n-2:0], i_ss};
      mosi_sync <= {mosi_sync[sync_n-2:0], i_mosi};
      sck_prev  <= sck_s;
      fetch_q   <= 1'b0;           // Strobes last a single cycle
      load_q    <= 1'b0;

      if (ss_s) begin
        // A partial frame is dropped between frames
        bit_cnt  <= '0;
        cs_q     <= '0;
        tx_shift <= '0;
      end else begin
        if (sck_rise && bit_cnt != cnt_frame_done) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == cnt_cmd_last) begin  // 8th edge closes the command
            cmd_q              <= cmd_next;
            cs_q               <= '0;
            cs_q[cmd_next.sel] <= 1'b1;
            fetch_q            <= cmd_next.rd;
          end
          if (bit_cnt == cnt_frame_last) begin  // 16th edge closes the data
            load_q <= ~cmd_q.rd;
          end
        end

        if (sck_fall) begin
          if (bit_cnt == cnt_cmd_done && cmd_q.rd) begin
            tx_shift <= i_read_data;  // Mux settled long before this edge
          end else begin
            tx_shift <= {tx_shift[data_w-2:0], 1'b0};
          end
        end
      end
    end
  end

  // Payload shift path
  always_ff @(posedge i_glob_clock) begin
    if (!ss_s && sck_rise) begin
      rx_shift <= rx_byte_next;
      if (bit_cnt == cnt_frame_last) begin
        wdata_q <= rx_byte_next;
      end
    end
  end

  assign o_miso = i_ss ? 1'b0 : tx_shift[data_w-1];  // Quiet line when not selected

  assign bus.ioc   = cmd_q.ioc;
  assign bus.wdata = wdata_q;
  assign bus.cs    = cs_q;
  assign bus.fetch = fetch_q;
  assign bus.load  = load_q;

endmodule

/* hw/sys_ctrl.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module sys_ctrl (
  input  logic                    i_glob_clock,
  input  logic                    i_rst_b,
  ctrl_bus_if.slave               bus,
  output logic [`CTRL_DATA_W-1:0] o_rdata
);

  logic                    sel;      // This block owns the current frame
  logic [`CTRL_DATA_W-1:0] scratch;  // Free register for host link tests

  assign sel = bus.cs[ctrl_bus_pkg::SEL_SYS];

  // ==================================================
  // Write side
  // ==================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      scratch <= '0;
    end else if (bus.load && sel) begin
      case (bus.ioc)
        ctrl_bus_pkg::SCRATCH: scratch <= bus.wdata;
        default: ;  // VERSION is read only and others do not exist
      endcase
    end
  end

  // ==================================================
  // Read side
  // ==================================================
  // Data is captured on fetch and then held for the top mux
  always_ff @(posedge i_glob_clock) begin
    if (bus.fetch && sel) begin
      case (bus.ioc)
        ctrl_bus_pkg::VERSION: o_rdata <= `CTRL_VERSION;
        ctrl_bus_pkg::SCRATCH: o_rdata <= scratch;
        default:               o_rdata <= '0;  // Unmapped index
      endcase
    end
  end

endmodule

/* testbench/ctrl_top_assert.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module ctrl_top_assert (
  input logic                   i_glob_clock,
  input logic                   i_rst_b,
  input logic [`CTRL_SEL_N-1:0] i_cs,
  input logic                   i_fetch,
  input logic                   i_load,
  input logic                   i_rx_h_tx_l,
  input logic                   i_rx_h_tx_l_b,
  input logic                   i_tr_vc1,
  input logic                   i_tr_vc1_b
);

  int fail_cnt = 0;  // Read by the testbench at the end of the run

  // ==================================================
  // Command strobes
  // ==================================================
  cs_onehot: assert property (@(posedge i_glob_clock) disable iff (!i_rst_b) $onehot0(i_cs))
    else begin
      $error("More than one module select active: %b", i_cs);
      fail_cnt++;
    end

  strobe_excl: assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
                                !(i_fetch && i_load))
    else begin
      $error("Fetch and load active in the same cycle");
      fail_cnt++;
    end

  // ==================================================
  // Complementary RF pins
  // ==================================================
  rx_pair: assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
                            i_rx_h_tx_l_b == !i_rx_h_tx_l)
    else begin
      $error("rx_h_tx_l pair not complementary");
      fail_cnt++;
    end

  vc1_pair: assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
                             i_tr_vc1_b == !i_tr_vc1)
    else begin
      $error("tr_vc1 pair not complementary");
      fail_cnt++;
    end

endmodule

bind ctrl_top ctrl_top_assert ctrl_top_assert_inst (
  .i_glob_clock  (i_glob_clock),
  .i_rst_b       (i_rst_b),
  .i_cs          (bus_if.cs),
  .i_fetch       (bus_if.fetch),
  .i_load        (bus_if.load),
  .i_rx_h_tx_l   (o_rx_h_tx_l),
  .i_rx_h_tx_l_b (o_rx_h_tx_l_b),
  .i_tr_vc1      (o_tr_vc1),
  .i_tr_vc1_b    (o_tr_vc1_b)
);

/* testbench/tb_ctrl_top.sv */
`timescale 1ns/1ps

module tb_ctrl_top;

  localparam int half_sck   = 8;      // Clocks per SCK half period
  localparam int max_cycles = 20000;  // About 50 frames of 260 cycles plus margin

  localparam logic [1:0] sel_sys  = 2'd0;
  localparam logic [1:0] sel_io   = 2'd1;
  localparam logic [1:0] sel_smi  = 2'd2;
  localparam logic [1:0] sel_rsvd = 2'd3;

  logic       clk;
  logic       rst_b;
  logic       sck;
  logic       ss;
  logic       mosi;
  logic       miso;
  logic [3:0] cfg;
  logic       button;
  logic       led0;
  logic       led1;
  logic [6:0] rf_out;             // rx, rx_b, vc1, vc1_b, vc2, shdn_rx, shdn_tx
  int         errors;
  int         seed;
  int         assert_fails;
  int         cycle_cnt = 0;

  ctrl_top ctrl_top_inst (
    .i_glob_clock  (clk),
    .i_rst_b       (rst_b),
    .i_sck         (sck),
    .i_ss          (ss),
    .i_mosi        (mosi),
    .o_miso        (miso),
    .i_config      (cfg),
    .i_button      (button),
    .o_led0        (led0),
    .o_led1        (led1),
    .o_rx_h_tx_l   (rf_out[6]),
    .o_rx_h_tx_l_b (rf_out[5]),
    .o_tr_vc1      (rf_out[4]),
    .o_tr_vc1_b    (rf_out[3]),
    .o_tr_vc2      (rf_out[2]),
    .o_shdn_rx_lna (rf_out[1]),
    .o_shdn_tx_lna (rf_out[0])
  );

  always #5 clk = ~clk;  // 10 ns period

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == max_cycles) begin
      $display("Timeout: run did not finish within %0d clock cycles", max_cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ==================================================
  // Helpers
  // ==================================================
  task automatic wait_clocks(input int n);
    repeat (n) @(negedge clk);  // Always return on a falling edge
  endtask

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s: expected 0x%02h, actual 0x%02h", name, exp, act);
      errors++;
    end
  endtask

  // Switch table with complements inserted and a zero top bit
  function automatic logic [7:0] rf_pins_expected(input int code);
    logic [4:0] sw;  // rx_h_tx_l, tr_vc1, tr_vc2, shdn_rx_lna, shdn_tx_lna
    case (code)
      1:       sw = 5'b11101;  // RX lowpass
      2:       sw = 5'b10101;  // RX hipass
      3:       sw = 5'b01110;  // TX lowpass
      4:       sw = 5'b00110;  // TX hipass
      5:       sw = 5'b11011;  // Bypass
      default: sw = 5'b10011;  // Low power and codes 6 and 7
    endcase
    return {1'b0, sw[4], ~sw[4], sw[3], ~sw[3], sw[2], sw[1], sw[0]};
  endfunction

  // Mode 0 frame sent MSB first
  // Fewer than 16 bits give an aborted frame
  task automatic spi_frame(input logic [7:0] cmd, input logic [7:0] data, input int nbits,
                           output logic [7:0] rx);
    logic [15:0] tx_bits;
    logic [15:0] rx_bits;
    int          i;
    tx_bits = {cmd, data};
    rx_bits = '0;
    @(negedge clk);
    ss = 1'b0;
    for (i = 15; i >= 16 - nbits; i--) begin
      mosi = tx_bits[i];        // Set while SCK is low
      wait_clocks(half_sck);
      rx_bits[i] = miso;        // Sample just before the rising edge
      sck = 1'b1;
      wait_clocks(half_sck);
      sck = 1'b0;
    end
    wait_clocks(half_sck);
    ss   = 1'b1;
    mosi = 1'b0;
    wait_clocks(half_sck);      // Idle gap between frames
    rx = rx_bits[7:0];
  endtask

  task automatic spi_write(input logic [1:0] sel, input logic [4:0] ioc, input logic [7:0] data);
    logic [7:0] unused_rx;
    spi_frame({1'b0, sel, ioc}, data, 16, unused_rx);
  endtask

  task automatic spi_read(input logic [1:0] sel, input logic [4:0] ioc, output logic [7:0] data);
    spi_frame({1'b1, sel, ioc}, 8'h00, 16, data);
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic test_reset_defaults();
    logic [7:0] rd;
    check_value("reset_rf_pins", rf_pins_expected(0), {1'b0, rf_out});
    check_value("reset_leds", 8'h00, {6'b0, led1, led0});
    check_value("reset_miso", 8'h00, {7'b0, miso});
    spi_read(sel_sys, 5'd0, rd);
    check_value("version", 8'h01, rd);
  endtask

  task automatic test_scratch();
    logic [7:0] wr;
    logic [7:0] rd;
    int         n;
    for (n = 0; n < 10; n++) begin
      wr = 8'($random(seed));
      spi_write(sel_sys, 5'd1, wr);
      spi_read(sel_sys, 5'd1, rd);
      check_value($sformatf("scratch_%0d", n), wr, rd);
    end
  endtask

  task automatic test_rf_modes();
    logic [7:0] rd;
    int         code;
    for (code = 0; code < 8; code++) begin
      spi_write(sel_io, 5'd0, 8'(code));
      check_value($sformatf("rf_pins_%0d", code), rf_pins_expected(code), {1'b0, rf_out});
      spi_read(sel_io, 5'd0, rd);
      check_value($sformatf("rf_mode_read_%0d", code), 8'(code), rd);
    end
  endtask

  task automatic test_pins_leds();
    logic [7:0] rd;
    int         n;
    for (n = 0; n < 4; n++) begin
      cfg    = 4'($random(seed));
      button = n[0];
      spi_read(sel_io, 5'd1, rd);  // Synchronizers settle well inside the frame
      check_value($sformatf("pins_%0d", n), {3'b0, button, cfg}, rd);
    end
    for (n = 0; n < 4; n++) begin
      spi_write(sel_io, 5'd2, 8'(n));
      check_value($sformatf("leds_%0d", n), 8'(n), {6'b0, led1, led0});
    end
  endtask

  task automatic test_readback_rules();
    logic [7:0] rd;
    spi_read(sel_smi, 5'd0, rd);
    check_value("smi_read", 8'h00, rd);
    spi_read(sel_rsvd, 5'd0, rd);
    check_value("reserved_read", 8'hA5, rd);
    spi_read(sel_sys, 5'd7, rd);
    check_value("sys_undefined_ioc", 8'h00, rd);
    spi_read(sel_io, 5'd9, rd);
    check_value("io_undefined_ioc", 8'h00, rd);
    spi_write(sel_sys, 5'd1, 8'h3C);
    spi_frame({1'b0, sel_sys, 5'd1}, 8'hC3, 12, rd);  // SS rises after bit 12
    spi_read(sel_sys, 5'd1, rd);
    check_value("aborted_write", 8'h3C, rd);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    clk    = 1'b0;
    rst_b  = 1'b0;
    sck    = 1'b0;
    ss     = 1'b1;
    mosi   = 1'b0;
    cfg    = 4'h0;
    button = 1'b0;
    errors = 0;
    seed   = 20;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_b = 1'b1;
    wait_clocks(4);

    test_reset_defaults();
    test_scratch();
    test_rf_modes();
    test_pins_leds();
    test_readback_rules();

    assert_fails = ctrl_top_inst.ctrl_top_assert_inst.fail_cnt;
    $display("Summary: %0d check errors, %0d assertion failures", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+hw
hw/ctrl_bus_pkg.sv
hw/rf_fe_pkg.sv
hw/ctrl_bus_if.sv
hw/spi_slave.sv
hw/sys_ctrl.sv
hw/io_ctrl.sv
hw/ctrl_top.sv
testbench/ctrl_top_assert.sv
testbench/tb_ctrl_top.sv
